//--- vlog.f
common/fm_pkg.sv
source/slot_counter.sv
source/reg_write_port.sv
op_regs/op_reg_ring.sv
source/ch_reg_mem.sv
source/keyon_ctrl.sv
source/alg_route.sv
source/fm_reg_file.sv
verification/fm_reg_file_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the fm register file testbench with verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f vlog.f --top-module fm_reg_file_tb -o fm_reg_file_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/fm_reg_file_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF 'All tests passed!' "$log"; then
    exit 0
fi
exit 1

//--- verification/fm_reg_file_tb.sv
// testbench for the fm register file, builds a table of writes and slot checks and applies it
`timescale 1ns/1ps

module fm_reg_file_tb;

    typedef enum int {
        sel_none, sel_tl, sel_dt1, sel_mul, sel_ks, sel_ar, sel_amsen, sel_d1r, sel_d2r,
        sel_sl, sel_rr, sel_ssg_en, sel_ssg_eg, sel_fnum, sel_block, sel_fb, sel_alg,
        sel_pan, sel_ams, sel_pms, sel_keyon, sel_carrier, sel_use_fb, sel_mod_src
    } sel_t;

    typedef struct {
        string       name;
        bit          wr;      // row starts with a write
        logic        bank;
        logic [7:0]  addr;
        logic [7:0]  data;
        logic [1:0]  op;      // slot to check on
        logic [2:0]  ch;
        sel_t        sel;
        logic [15:0] exp_val;
    } row_t;

    logic        clk, rst, wr_valid, wr_ready, wr_bank, frame_start;
    logic [7:0]  wr_addr, wr_data;
    logic [1:0]  slot_op, ks, pan, ams;
    logic [2:0]  slot_ch, dt1, ssg_eg, block, fb, alg, pms;
    logic [3:0]  mul, sl, rr, mod_src;
    logic [4:0]  ar, d1r, d2r;
    logic [6:0]  tl;
    logic [10:0] fnum;
    logic        amsen, ssg_en, keyon, carrier, use_fb;

    logic [15:0] lfsr_state;
    int          n_err;
    int          n_timeout;
    row_t        rows[$];

    // operator register bases and the fields each one carries
    logic [7:0] op_bases [7] = '{8'h30, 8'h40, 8'h50, 8'h60, 8'h70, 8'h80, 8'h90};
    sel_t first_sel [7] = '{sel_dt1, sel_tl, sel_ks, sel_amsen, sel_d2r, sel_sl, sel_ssg_en};
    sel_t second_sel [7] = '{sel_mul, sel_none, sel_ar, sel_d1r, sel_none, sel_rr, sel_ssg_eg};
    // write targets, slots op0/ch4, op2/ch5 and op0/ch3 are never written
    logic       tgt_bank [4] = '{1'b0, 1'b1, 1'b0, 1'b1};
    logic [1:0] tgt_op [4]   = '{2'd0, 2'd2, 2'd3, 2'd1};
    logic [1:0] tgt_chl [4]  = '{2'd0, 2'd1, 2'd2, 2'd0};

    fm_reg_file dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // fibonacci lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);  // one step per bit
            b = {b[6:0], lfsr_state[0]};
        end
        return b;
    endfunction

    // field a register byte leaves in the operator outputs
    function automatic logic [15:0] op_field(input sel_t s, input logic [7:0] d);
        case (s)
            sel_dt1:    return 16'(d[6:4]);
            sel_mul:    return 16'(d[3:0]);
            sel_tl:     return 16'(d[6:0]);
            sel_ks:     return 16'(d[7:6]);
            sel_amsen:  return 16'(d[7]);
            sel_sl:     return 16'(d[7:4]);
            sel_rr:     return 16'(d[3:0]);
            sel_ssg_en: return 16'(d[3]);
            sel_ssg_eg: return 16'(d[2:0]);
            default:    return 16'(d[4:0]);  // ar, d1r, d2r
        endcase
    endfunction

    function automatic logic [15:0] read_sel(input sel_t s);
        case (s)
            sel_tl:      return 16'(tl);
            sel_dt1:     return 16'(dt1);
            sel_mul:     return 16'(mul);
            sel_ks:      return 16'(ks);
            sel_ar:      return 16'(ar);
            sel_amsen:   return 16'(amsen);
            sel_d1r:     return 16'(d1r);
            sel_d2r:     return 16'(d2r);
            sel_sl:      return 16'(sl);
            sel_rr:      return 16'(rr);
            sel_ssg_en:  return 16'(ssg_en);
            sel_ssg_eg:  return 16'(ssg_eg);
            sel_fnum:    return 16'(fnum);
            sel_block:   return 16'(block);
            sel_fb:      return 16'(fb);
            sel_alg:     return 16'(alg);
            sel_pan:     return 16'(pan);
            sel_ams:     return 16'(ams);
            sel_pms:     return 16'(pms);
            sel_keyon:   return 16'(keyon);
            sel_carrier: return 16'(carrier);
            sel_use_fb:  return 16'(use_fb);
            sel_mod_src: return 16'(mod_src);
            default:     return 16'hFFFF;
        endcase
    endfunction

    // output operators per algorithm, op 0 is operator 1
    function automatic logic carrier_exp(input int a, input int op);
        case (a)
            0, 1, 2, 3: return op == 3;
            4:          return op == 1 || op == 3;
            5, 6:       return op != 0;
            default:    return 1'b1;
        endcase
    endfunction

    // earlier operators feeding each operator, bit n is operator n+1
    function automatic logic [3:0] mod_src_exp(input int a, input int op);
        case (a)
            0:       return op == 0 ? 4'h0 : 4'(1 << (op - 1));  // serial chain
            1:       return op == 2 ? 4'h3 : (op == 3 ? 4'h4 : 4'h0);
            2:       return op == 2 ? 4'h2 : (op == 3 ? 4'h5 : 4'h0);
            3:       return op == 1 ? 4'h1 : (op == 3 ? 4'h6 : 4'h0);
            4:       return op == 1 ? 4'h1 : (op == 3 ? 4'h4 : 4'h0);
            5:       return op == 0 ? 4'h0 : 4'h1;
            6:       return op == 1 ? 4'h1 : 4'h0;
            default: return 4'h0;  // all carriers
        endcase
    endfunction

    task automatic add_row(input string name, input bit wr, input logic bank,
                           input logic [7:0] addr, input logic [7:0] data, input logic [1:0] op,
                           input logic [2:0] ch, input sel_t sel, input logic [15:0] exp_val);
        row_t r;
        r.name    = name;
        r.wr      = wr;
        r.bank    = bank;
        r.addr    = addr;
        r.data    = data;
        r.op      = op;
        r.ch      = ch;
        r.sel     = sel;
        r.exp_val = exp_val;
        rows.push_back(r);
    endtask

    task automatic add_op_rows(input int r, input int t);
        logic [7:0] addr;
        logic [7:0] data;
        logic [2:0] ch;
        string      name;
        addr = op_bases[r] | {4'h0, tgt_op[t], tgt_chl[t]};
        ch   = {1'b0, tgt_chl[t]} + (tgt_bank[t] ? 3'd3 : 3'd0);
        data = rand_byte();
        name = $sformatf("op%02h_b%0d", addr, tgt_bank[t]);
        add_row(name, 1'b1, tgt_bank[t], addr, data, tgt_op[t], ch, first_sel[r],
                op_field(first_sel[r], data));
        if (second_sel[r] != sel_none) begin
            add_row(name, 1'b0, tgt_bank[t], addr, data, tgt_op[t], ch, second_sel[r],
                    op_field(second_sel[r], data));
        end
    endtask

    task automatic build_table();
        logic [7:0] d;
        logic [7:0] hi;
        logic [7:0] chl;
        logic [2:0] ch;
        logic [2:0] fb_v;
        logic       bank;
        for (int r = 0; r < 7; r++) begin
            add_op_rows(r, r % 4);
            add_op_rows(r, (r + 1) % 4);
        end
        add_row("untouched_tl", 1'b0, 1'b0, 8'h00, 8'h00, 2'd0, 3'd4, sel_tl, 16'd0);
        add_row("untouched_ar", 1'b0, 1'b0, 8'h00, 8'h00, 2'd2, 3'd5, sel_ar, 16'd0);
        add_row("ch_field3", 1'b1, 1'b0, 8'h43, 8'h7F, 2'd0, 3'd3, sel_tl, 16'd0);
        add_row("bad_addr", 1'b1, 1'b1, 8'h20, 8'hFF, 2'd0, 3'd3, sel_tl, 16'd0);
        for (int k = 0; k < 2; k++) begin
            bank = k == 1;
            chl  = (k == 1) ? 8'd2 : 8'd1;
            ch   = (k == 1) ? 3'd5 : 3'd1;
            hi   = rand_byte() & 8'h3F;
            d    = rand_byte();
            add_row("fnum_hi", 1'b1, bank, 8'hA4 | chl, hi, 2'd0, ch, sel_none, 16'd0);
            add_row("fnum_lo", 1'b1, bank, 8'hA0 | chl, d, 2'd1, ch, sel_fnum, {5'd0, hi[2:0], d});
            add_row("fnum_block", 1'b0, bank, 8'h00, 8'h00, 2'd3, ch, sel_block, 16'(hi[5:3]));
            d = rand_byte() & 8'h3F;
            add_row("fb_alg", 1'b1, bank, 8'hB0 | chl, d, 2'd2, ch, sel_fb, 16'(d[5:3]));
            add_row("fb_alg", 1'b0, bank, 8'h00, 8'h00, 2'd0, ch, sel_alg, 16'(d[2:0]));
            d = rand_byte();
            add_row("pan_ms", 1'b1, bank, 8'hB4 | chl, d, 2'd0, ch, sel_pan, 16'(d[7:6]));
            add_row("pan_ms", 1'b0, bank, 8'h00, 8'h00, 2'd1, ch, sel_ams, 16'(d[5:4]));
            add_row("pan_ms", 1'b0, bank, 8'h00, 8'h00, 2'd2, ch, sel_pms, 16'(d[2:0]));
        end
        // key-on, mask in the high nibble
        for (int o = 0; o < 4; o++) begin
            add_row("keyon_a5", o == 0, 1'b0, 8'h28, 8'hA5, 2'(o), 3'd4, sel_keyon, 16'(o % 2));
        end
        add_row("keyon_a5", 1'b0, 1'b0, 8'h00, 8'h00, 2'd1, 3'd1, sel_keyon, 16'd0);
        for (int o = 0; o < 4; o++) begin
            add_row("keyon_51", o == 0, 1'b0, 8'h28, 8'h51, 2'(o), 3'd1, sel_keyon,
                    16'((o + 1) % 2));
        end
        add_row("keyon_f3", 1'b1, 1'b0, 8'h28, 8'hF3, 2'd0, 3'd3, sel_keyon, 16'd0);
        add_row("keyon_f3", 1'b0, 1'b0, 8'h00, 8'h00, 2'd0, 3'd4, sel_keyon, 16'd0);
        add_row("keyon_f7", 1'b1, 1'b0, 8'h28, 8'hF7, 2'd0, 3'd5, sel_keyon, 16'd0);
        add_row("keyon_f7", 1'b0, 1'b0, 8'h00, 8'h00, 2'd2, 3'd4, sel_keyon, 16'd0);
        // routing on channel 0, feedback only on odd algorithms
        for (int a = 0; a < 8; a++) begin
            fb_v = a[0] ? 3'(a) : 3'd0;
            d    = {2'b00, fb_v, 3'(a)};
            for (int o = 0; o < 4; o++) begin
                add_row($sformatf("alg%0d", a), o == 0, 1'b0, 8'hB0, d, 2'(o), 3'd0,
                        sel_carrier, 16'(carrier_exp(a, o)));
            end
            for (int o = 0; o < 4; o++) begin
                add_row($sformatf("alg%0d", a), 1'b0, 1'b0, 8'h00, 8'h00, 2'(o), 3'd0,
                        sel_mod_src, 16'(mod_src_exp(a, o)));
            end
            add_row($sformatf("alg%0d", a), 1'b0, 1'b0, 8'h00, 8'h00, 2'd0, 3'd0, sel_use_fb,
                    16'(fb_v != 3'd0));
        end
    endtask

    task automatic do_write(input row_t r);
        bit op_wr;
        int n;
        op_wr = r.addr >= 8'h30 && r.addr < 8'hA0 && r.addr[1:0] != 2'd3;
        @(posedge clk);
        wr_valid <= 1'b1;
        wr_bank  <= r.bank;
        wr_addr  <= r.addr;
        wr_data  <= r.data;
        n = 0;
        @(negedge clk);
        while (!wr_ready && n < 30) begin
            @(negedge clk);
            n++;
        end
        assert (wr_ready) else begin
            $display("%s: write was never accepted, wr_ready stayed low", r.name);
            n_timeout++;
        end
        @(posedge clk);  // accepting edge
        wr_valid <= 1'b0;
        @(negedge clk);
        assert (wr_ready == !op_wr) else begin
            $display("ERR %s wr_ready expected %0d actual %0d", r.name, !op_wr, wr_ready);
            n_err++;
        end
        n = 0;
        while (!wr_ready && n < 25) begin  // held until the target slot passes
            @(negedge clk);
            n++;
        end
        assert (wr_ready) else begin
            $display("%s: wr_ready did not return high within 25 cycles", r.name);
            n_timeout++;
        end
    endtask

    task automatic check_row(input row_t r);
        int          n;
        logic        at_slot;
        logic [15:0] got;
        n = 0;
        @(negedge clk);
        while (!(slot_op == r.op && slot_ch == r.ch) && n < 30) begin
            @(negedge clk);
            n++;
        end
        at_slot = slot_op == r.op && slot_ch == r.ch;
        assert (at_slot) else begin
            $display("%s: slot op %0d ch %0d was never shown", r.name, r.op, r.ch);
            n_timeout++;
        end
        if (at_slot) begin
            got = read_sel(r.sel);
            assert (got == r.exp_val) else begin
                $display("ERR %s %s expected %0h actual %0h", r.name, r.sel.name(),
                         r.exp_val, got);
                n_err++;
            end
        end
    endtask

    task automatic check_slot_order();
        int         n;
        logic [1:0] op_exp;
        logic [2:0] ch_exp;
        n = 0;
        @(negedge clk);
        while (!frame_start && n < 30) begin
            @(negedge clk);
            n++;
        end
        assert (frame_start) else begin
            $display("slot_order: frame_start did not come back within 30 cycles");
            n_timeout++;
        end
        op_exp = 2'd0;
        ch_exp = 3'd0;
        for (int i = 0; i < 48; i++) begin
            assert (slot_op == op_exp && slot_ch == ch_exp && frame_start == (i % 24 == 0))
            else begin
                $display("ERR slot_order step %0d expected op %0d ch %0d fs %0d actual %0d %0d %0d",
                         i, op_exp, ch_exp, i % 24 == 0, slot_op, slot_ch, frame_start);
                n_err++;
            end
            if (ch_exp == 3'd5) begin
                ch_exp = 3'd0;
                op_exp = op_exp + 2'd1;
            end else begin
                ch_exp = ch_exp + 3'd1;
            end
            @(negedge clk);
        end
    endtask

    initial begin
        rst        = 1'b1;
        wr_valid   = 1'b0;
        wr_bank    = 1'b0;
        wr_addr    = 8'h00;
        wr_data    = 8'h00;
        n_err      = 0;
        n_timeout  = 0;
        lfsr_state = 16'd28680;
        build_table();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (wr_ready && frame_start && slot_op == 2'd0 && slot_ch == 3'd0) else begin
            $display("ERR reset expected ready 1 fs 1 slot 0 actual %0d %0d %0d/%0d",
                     wr_ready, frame_start, slot_op, slot_ch);
            n_err++;
        end
        check_slot_order();
        foreach (rows[i]) begin
            if (rows[i].wr) begin
                do_write(rows[i]);
            end
            if (rows[i].sel != sel_none) begin
                check_row(rows[i]);
            end
        end
        $display("rows: %0d, value errors: %0d, timeouts: %0d", rows.size(), n_err, n_timeout);
        if (n_err == 0 && n_timeout == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- source/fm_reg_file.sv
// top level of the fm register file, presents every parameter of the current slot each cycle
`timescale 1ns/1ps

module fm_reg_file (
    input  logic        clk,
    input  logic        rst,
    input  logic        wr_valid,
    output logic        wr_ready,
    input  logic        wr_bank,
    input  logic [7:0]  wr_addr,
    input  logic [7:0]  wr_data,
    output logic [1:0]  slot_op,
    output logic [2:0]  slot_ch,
    output logic        frame_start,
    output logic [6:0]  tl,
    output logic [2:0]  dt1,
    output logic [3:0]  mul,
    output logic [1:0]  ks,
    output logic [4:0]  ar,
    output logic        amsen,
    output logic [4:0]  d1r,
    output logic [4:0]  d2r,
    output logic [3:0]  sl,
    output logic [3:0]  rr,
    output logic        ssg_en,
    output logic [2:0]  ssg_eg,
    output logic [10:0] fnum,
    output logic [2:0]  block,
    output logic [2:0]  fb,
    output logic [2:0]  alg,
    output logic [1:0]  pan,
    output logic [1:0]  ams,
    output logic [2:0]  pms,
    output logic        keyon,
    output logic        carrier,
    output logic        use_fb,
    output logic [3:0]  mod_src
);

    logic [4:0]                   slot_idx;
    logic [6:0]                   op_upd;
    logic [7:0]                   op_din;
    logic [3:0]                   ch_upd;
    logic [2:0]                   ch_sel;
    logic [7:0]                   ch_din;
    logic                         kon_we;
    logic [7:0]                   kon_din;
    logic [fm_pkg::op_word_w-1:0] head;

    slot_counter counter_i (
        .clk(clk), .rst(rst), .slot_op(slot_op), .slot_ch(slot_ch),
        .slot_idx(slot_idx), .frame_start(frame_start)
    );

    reg_write_port port_i (
        .clk(clk), .rst(rst), .wr_valid(wr_valid), .wr_ready(wr_ready),
        .wr_bank(wr_bank), .wr_addr(wr_addr), .wr_data(wr_data), .slot_idx(slot_idx),
        .op_upd(op_upd), .op_din(op_din), .ch_upd(ch_upd), .ch_sel(ch_sel),
        .ch_din(ch_din), .kon_we(kon_we), .kon_din(kon_din)
    );

    op_reg_ring ring_i (
        .clk(clk), .rst(rst), .op_upd(op_upd), .op_din(op_din), .head(head)
    );

    ch_reg_mem chmem_i (
        .clk(clk), .rst(rst), .ch_upd(ch_upd), .ch_sel(ch_sel), .ch_din(ch_din),
        .slot_ch(slot_ch), .fnum(fnum), .block(block), .fb(fb), .alg(alg),
        .pan(pan), .ams(ams), .pms(pms)
    );

    keyon_ctrl kon_i (
        .clk(clk), .rst(rst), .kon_we(kon_we), .kon_din(kon_din),
        .slot_op(slot_op), .slot_ch(slot_ch), .keyon(keyon)
    );

    alg_route route_i (
        .alg(alg), .fb(fb), .slot_op(slot_op),
        .carrier(carrier), .use_fb(use_fb), .mod_src(mod_src)
    );

    // head word fields
    assign tl     = head[fm_pkg::tl_lsb +: 7];
    assign dt1    = head[fm_pkg::dt1_lsb +: 3];
    assign mul    = head[fm_pkg::mul_lsb +: 4];
    assign ks     = head[fm_pkg::ks_lsb +: 2];
    assign ar     = head[fm_pkg::ar_lsb +: 5];
    assign amsen  = head[fm_pkg::amsen_lsb];
    assign d1r    = head[fm_pkg::d1r_lsb +: 5];
    assign d2r    = head[fm_pkg::d2r_lsb +: 5];
    assign sl     = head[fm_pkg::sl_lsb +: 4];
    assign rr     = head[fm_pkg::rr_lsb +: 4];
    assign ssg_en = head[fm_pkg::ssg_lsb + 3];
    assign ssg_eg = head[fm_pkg::ssg_lsb +: 3];

endmodule

//--- source/alg_route.sv
// algorithm decoder, gives carrier, feedback and modulation-source flags for the current operator
`timescale 1ns/1ps

module alg_route (
    input  logic [2:0] alg,
    input  logic [2:0] fb,
    input  logic [1:0] slot_op,
    output logic       carrier,
    output logic       use_fb,
    output logic [3:0] mod_src
);

    logic [3:0] carrier_mask;

    assign carrier_mask = fm_pkg::alg_carrier[alg];
    assign carrier      = carrier_mask[slot_op];

    // only operator 1 feeds back on itself
    assign use_fb = (slot_op == 2'd0) && (fb != 3'd0);

    assign mod_src = fm_pkg::alg_mod_src[alg][slot_op];

endmodule

//--- source/keyon_ctrl.sv
// key-on state per slot, loaded from the key-on register and read out for the current slot
`timescale 1ns/1ps

module keyon_ctrl (
    input  logic       clk,
    input  logic       rst,
    input  logic       kon_we,
    input  logic [7:0] kon_din,
    input  logic [1:0] slot_op,
    input  logic [2:0] slot_ch,
    output logic       keyon
);

    logic [3:0] kon_bits [fm_pkg::num_ch];  // operator mask per channel
    logic [2:0] kon_ch;
    logic       code_ok;

    // code bit 2 picks the upper bank, low code 3 is unused
    assign code_ok = kon_din[1:0] != 2'd3;
    assign kon_ch  = 3'(kon_din[1:0]) + (kon_din[2] ? 3'd3 : 3'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < fm_pkg::num_ch; i++) begin
                kon_bits[i] <= '0;
            end
        end else if (kon_we && code_ok) begin
            kon_bits[kon_ch] <= kon_din[7:4];
        end
    end

    assign keyon = kon_bits[slot_ch][slot_op];

endmodule

//--- source/ch_reg_mem.sv
// per-channel register storage with the shared frequency high-byte latch
`timescale 1ns/1ps

module ch_reg_mem (
    input  logic        clk,
    input  logic        rst,
    input  logic [3:0]  ch_upd,
    input  logic [2:0]  ch_sel,
    input  logic [7:0]  ch_din,
    input  logic [2:0]  slot_ch,
    output logic [10:0] fnum,
    output logic [2:0]  block,
    output logic [2:0]  fb,
    output logic [2:0]  alg,
    output logic [1:0]  pan,
    output logic [1:0]  ams,
    output logic [2:0]  pms
);

    logic [10:0] fnum_mem  [fm_pkg::num_ch];
    logic [2:0]  block_mem [fm_pkg::num_ch];
    logic [2:0]  fb_mem    [fm_pkg::num_ch];
    logic [2:0]  alg_mem   [fm_pkg::num_ch];
    logic [1:0]  pan_mem   [fm_pkg::num_ch];
    logic [1:0]  ams_mem   [fm_pkg::num_ch];
    logic [2:0]  pms_mem   [fm_pkg::num_ch];
    logic [5:0]  fhi_latch; // block, fnum[10:8]

    always_ff @(posedge clk) begin
        if (rst) begin
            fhi_latch <= '0;
            for (int i = 0; i < fm_pkg::num_ch; i++) begin
                fnum_mem[i]  <= '0;
                block_mem[i] <= '0;
                fb_mem[i]    <= '0;
                alg_mem[i]   <= '0;
                pan_mem[i]   <= '0;
                ams_mem[i]   <= '0;
                pms_mem[i]   <= '0;
            end
        end else begin
            if (ch_upd[fm_pkg::upd_fnum_hi]) begin
                fhi_latch <= ch_din[5:0];
            end
            if (ch_upd[fm_pkg::upd_fnum_lo]) begin  // commits latch too
                fnum_mem[ch_sel]  <= {fhi_latch[2:0], ch_din};
                block_mem[ch_sel] <= fhi_latch[5:3];
            end
            if (ch_upd[fm_pkg::upd_fb_alg]) begin
                fb_mem[ch_sel]  <= ch_din[5:3];
                alg_mem[ch_sel] <= ch_din[2:0];
            end
            if (ch_upd[fm_pkg::upd_pan_ms]) begin
                pan_mem[ch_sel] <= ch_din[7:6];
                ams_mem[ch_sel] <= ch_din[5:4];
                pms_mem[ch_sel] <= ch_din[2:0];
            end
        end
    end

    assign fnum  = fnum_mem[slot_ch];
    assign block = block_mem[slot_ch];
    assign fb    = fb_mem[slot_ch];
    assign alg   = alg_mem[slot_ch];
    assign pan   = pan_mem[slot_ch];
    assign ams   = ams_mem[slot_ch];
    assign pms   = pms_mem[slot_ch];

endmodule

//--- op_regs/op_reg_ring.sv
// circulating ring of operator parameter words, the head word always belongs to the current slot
`timescale 1ns/1ps

module op_reg_ring (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [6:0]                  op_upd,
    input  logic [7:0]                  op_din,
    output logic [fm_pkg::op_word_w-1:0] head
);

    logic [fm_pkg::op_word_w-1:0] ring [fm_pkg::num_slot];
    logic [fm_pkg::op_word_w-1:0] head_upd;

    assign head = ring[0];

    // rewrite the fields of the selected register, others pass unchanged
    always_comb begin
        head_upd = head;
        if (op_upd[fm_pkg::upd_dt_mul]) begin
            head_upd[fm_pkg::dt1_lsb +: 3] = op_din[6:4];
            head_upd[fm_pkg::mul_lsb +: 4] = op_din[3:0];
        end
        if (op_upd[fm_pkg::upd_tl]) begin
            head_upd[fm_pkg::tl_lsb +: 7] = op_din[6:0];
        end
        if (op_upd[fm_pkg::upd_ks_ar]) begin
            head_upd[fm_pkg::ks_lsb +: 2] = op_din[7:6];
            head_upd[fm_pkg::ar_lsb +: 5] = op_din[4:0];
        end
        if (op_upd[fm_pkg::upd_am_dr]) begin
            head_upd[fm_pkg::amsen_lsb]    = op_din[7];
            head_upd[fm_pkg::d1r_lsb +: 5] = op_din[4:0];
        end
        if (op_upd[fm_pkg::upd_sr]) begin
            head_upd[fm_pkg::d2r_lsb +: 5] = op_din[4:0];
        end
        if (op_upd[fm_pkg::upd_sl_rr]) begin
            head_upd[fm_pkg::sl_lsb +: 4] = op_din[7:4];
            head_upd[fm_pkg::rr_lsb +: 4] = op_din[3:0];
        end
        if (op_upd[fm_pkg::upd_ssg]) begin
            head_upd[fm_pkg::ssg_lsb +: 4] = op_din[3:0];  // enable + mode
        end
    end

    // shift toward the head, old head goes to the tail
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < fm_pkg::num_slot; i++) begin
                ring[i] <= '0;
            end
        end else begin
            for (int i = 0; i < fm_pkg::num_slot - 1; i++) begin
                ring[i] <= ring[i+1];
            end
            ring[fm_pkg::num_slot-1] <= head_upd;
        end
    end

endmodule

//--- source/reg_write_port.sv
// host write port, decodes byte writes into operator, channel and key-on update strobes
`timescale 1ns/1ps

module reg_write_port (
    input  logic       clk,
    input  logic       rst,
    input  logic       wr_valid,
    output logic       wr_ready,
    input  logic       wr_bank,
    input  logic [7:0] wr_addr,
    input  logic [7:0] wr_data,
    input  logic [4:0] slot_idx,
    output logic [6:0] op_upd,
    output logic [7:0] op_din,
    output logic [3:0] ch_upd,
    output logic [2:0] ch_sel,
    output logic [7:0] ch_din,
    output logic       kon_we,
    output logic [7:0] kon_din
);

    logic       accept;
    logic       ch_ok;      // channel field 3 is not a channel
    logic [2:0] tgt_ch;
    logic [4:0] tgt_slot;
    logic [6:0] op_hit;
    logic [3:0] ch_hit;
    logic       op_fire;

    // held operator write
    logic       pend;
    logic [4:0] pend_slot;
    logic [6:0] pend_field;
    logic [7:0] pend_data;

    assign wr_ready = !pend;
    assign accept   = wr_valid && wr_ready;
    assign ch_ok    = wr_addr[1:0] != 2'd3;
    assign tgt_ch   = 3'(wr_addr[1:0]) + (wr_bank ? 3'd3 : 3'd0);
    assign tgt_slot = 5'(wr_addr[3:2] * fm_pkg::num_ch) + 5'(tgt_ch);

    always_comb begin
        op_hit = '0;
        ch_hit = '0;
        if (ch_ok) begin
            case (wr_addr[7:4])
                fm_pkg::op_base_dt_mul[7:4]: op_hit[fm_pkg::upd_dt_mul] = 1'b1;
                fm_pkg::op_base_tl[7:4]:     op_hit[fm_pkg::upd_tl]     = 1'b1;
                fm_pkg::op_base_ks_ar[7:4]:  op_hit[fm_pkg::upd_ks_ar]  = 1'b1;
                fm_pkg::op_base_am_dr[7:4]:  op_hit[fm_pkg::upd_am_dr]  = 1'b1;
                fm_pkg::op_base_sr[7:4]:     op_hit[fm_pkg::upd_sr]     = 1'b1;
                fm_pkg::op_base_sl_rr[7:4]:  op_hit[fm_pkg::upd_sl_rr]  = 1'b1;
                fm_pkg::op_base_ssg[7:4]:    op_hit[fm_pkg::upd_ssg]    = 1'b1;
                default: ;
            endcase
            case (wr_addr[7:2])
                fm_pkg::ch_addr_fnum_lo[7:2]: ch_hit[fm_pkg::upd_fnum_lo] = 1'b1;
                fm_pkg::ch_addr_fnum_hi[7:2]: ch_hit[fm_pkg::upd_fnum_hi] = 1'b1;
                fm_pkg::ch_addr_fb_alg[7:2]:  ch_hit[fm_pkg::upd_fb_alg]  = 1'b1;
                fm_pkg::ch_addr_pan_ms[7:2]:  ch_hit[fm_pkg::upd_pan_ms]  = 1'b1;
                default: ;
            endcase
        end
    end

    // channel and key-on writes land on the accepting edge
    assign ch_upd  = accept ? ch_hit : 4'd0;
    assign ch_sel  = tgt_ch;
    assign ch_din  = wr_data;
    assign kon_we  = accept && (wr_addr == fm_pkg::ch_addr_keyon);
    assign kon_din = wr_data;

    // operator strobe only while the ring head holds the target slot
    assign op_fire = pend && (slot_idx == pend_slot);
    assign op_upd  = op_fire ? pend_field : 7'd0;
    assign op_din  = pend_data;

    always_ff @(posedge clk) begin
        if (rst) begin
            pend       <= 1'b0;
            pend_field <= '0;
        end else if (accept && |op_hit) begin
            pend       <= 1'b1;
            pend_field <= op_hit;
        end else if (op_fire) begin
            pend <= 1'b0;  // ready again after the update edge
        end
    end

    always_ff @(posedge clk) begin
        if (accept && |op_hit) begin
            pend_slot <= tgt_slot;
            pend_data <= wr_data;
        end
    end

endmodule

//--- source/slot_counter.sv
// free-running slot sequencer, the common time base that all register blocks index by
`timescale 1ns/1ps

module slot_counter (
    input  logic       clk,
    input  logic       rst,
    output logic [1:0] slot_op,
    output logic [2:0] slot_ch,
    output logic [4:0] slot_idx,
    output logic       frame_start
);

    logic last_ch;
    logic last_slot;

    assign last_ch   = slot_ch == 3'(fm_pkg::num_ch - 1);
    assign last_slot = slot_idx == 5'(fm_pkg::num_slot - 1);

    // channel runs fastest, operator steps after the last channel
    always_ff @(posedge clk) begin
        if (rst) begin
            slot_op  <= '0;
            slot_ch  <= '0;
            slot_idx <= '0;
        end else begin
            slot_ch  <= last_ch ? 3'd0 : slot_ch + 3'd1;
            slot_op  <= last_ch ? slot_op + 2'd1 : slot_op; // wraps 3 -> 0 by width
            slot_idx <= last_slot ? 5'd0 : slot_idx + 5'd1;
        end
    end

    assign frame_start = slot_idx == 5'd0;

endmodule

//--- common/fm_pkg.sv
// shared constants for the fm register file: slot counts, register map, ring layout, routing tables
package fm_pkg;

    localparam int num_ch    = 6;
    localparam int num_op    = 4;
    localparam int num_slot  = num_ch * num_op;
    localparam int op_word_w = 44;

    // operator register bases, addr[3:2] operator, addr[1:0] channel in bank
    localparam logic [7:0] op_base_dt_mul = 8'h30;
    localparam logic [7:0] op_base_tl     = 8'h40;
    localparam logic [7:0] op_base_ks_ar  = 8'h50;
    localparam logic [7:0] op_base_am_dr  = 8'h60;
    localparam logic [7:0] op_base_sr     = 8'h70;
    localparam logic [7:0] op_base_sl_rr  = 8'h80;
    localparam logic [7:0] op_base_ssg    = 8'h90;

    // channel registers
    localparam logic [7:0] ch_addr_fnum_lo = 8'hA0;
    localparam logic [7:0] ch_addr_fnum_hi = 8'hA4;
    localparam logic [7:0] ch_addr_fb_alg  = 8'hB0;
    localparam logic [7:0] ch_addr_pan_ms  = 8'hB4;
    localparam logic [7:0] ch_addr_keyon   = 8'h28;

    // bit of each register inside the op_upd one-hot
    localparam int upd_dt_mul = 0;
    localparam int upd_tl     = 1;
    localparam int upd_ks_ar  = 2;
    localparam int upd_am_dr  = 3;
    localparam int upd_sr     = 4;
    localparam int upd_sl_rr  = 5;
    localparam int upd_ssg    = 6;

    // bit of each register inside the ch_upd strobes
    localparam int upd_fnum_lo = 0;
    localparam int upd_fnum_hi = 1;
    localparam int upd_fb_alg  = 2;
    localparam int upd_pan_ms  = 3;

    // ring word layout, lsb of each field
    localparam int ssg_lsb   = 0;   // 4 bits, enable on top
    localparam int rr_lsb    = 4;   // 4 bits
    localparam int sl_lsb    = 8;   // 4 bits
    localparam int d2r_lsb   = 12;  // 5 bits
    localparam int d1r_lsb   = 17;  // 5 bits
    localparam int amsen_lsb = 22;  // 1 bit
    localparam int ar_lsb    = 23;  // 5 bits
    localparam int ks_lsb    = 28;  // 2 bits
    localparam int mul_lsb   = 30;  // 4 bits
    localparam int dt1_lsb   = 34;  // 3 bits
    localparam int tl_lsb    = 37;  // 7 bits, ends at bit 43

    // carrier mask per algorithm, bit n is operator n+1
    localparam logic [7:0][3:0] alg_carrier = {
        4'hF, 4'hE, 4'hE, 4'hA, 4'h8, 4'h8, 4'h8, 4'h8
    };

    // modulation sources indexed [alg][op], each entry a mask of earlier operators
    // one 16-bit word per algorithm, operator 4 in the top nibble
    localparam logic [7:0][3:0][3:0] alg_mod_src = {
        16'h0000, 16'h0010, 16'h1110, 16'h4010,
        16'h6010, 16'h5200, 16'h4300, 16'h4210
    };

endpackage
